// ==== Bender.yml ====
package:
  name: phold_engine

sources:
  - files:
      - hw/phold_pkg.sv
      - hw/rr_arbiter.sv
      - hw/lfsr.sv
      - hw/event_queue.sv
      - hw/history_table.sv
      - hw/phold_core.sv
      - hw/phold_top.sv
  - target: test
    files:
      - verification/phold_tb.sv

// ==== hw/event_queue.sv ====
`timescale 1ns/1ps

module event_queue #(
   parameter int QUEUE_DEPTH = 32
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              enq,
   input  logic              deq,
   input  phold_pkg::event_t in_event,
   output phold_pkg::event_t head,
   output logic              empty,
   output logic              full
);

   phold_pkg::event_t    slot [QUEUE_DEPTH]; // sorted by time, slot 0 earliest
   logic [QUEUE_DEPTH-1:0] vld;
   logic [QUEUE_DEPTH-1:0] stay;             // entry keeps its place on insert

   // equal times stay ahead of the new event
   always_comb begin
      for (int i = 0; i < QUEUE_DEPTH; i++)
         stay[i] = vld[i] &&
                   (slot[i][phold_pkg::TIME_WID-1:0] <= in_event[phold_pkg::TIME_WID-1:0]);
   end

   always_ff @(posedge clk) begin
      if (enq) begin
         if (!stay[0])
            slot[0] <= in_event;
         for (int i = 1; i < QUEUE_DEPTH; i++) begin
            if (stay[i-1] && !stay[i])
               slot[i] <= in_event; // insertion point
            else if (!stay[i])
               slot[i] <= slot[i-1]; // make room
         end
      end else if (deq) begin
         for (int i = 0; i < QUEUE_DEPTH - 1; i++)
            slot[i] <= slot[i+1];
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         vld <= '0;
      end else if (enq) begin
         if (!stay[0])
            vld[0] <= 1'b1;
         for (int i = 1; i < QUEUE_DEPTH; i++) begin
            if (stay[i-1] && !stay[i])
               vld[i] <= 1'b1;
            else if (!stay[i])
               vld[i] <= vld[i-1];
         end
      end else if (deq) begin
         vld <= {1'b0, vld[QUEUE_DEPTH-1:1]};
      end
   end

   assign head  = slot[0];
   assign empty = !vld[0];
   assign full  = vld[QUEUE_DEPTH-1];

   a_no_overflow:  assert property (@(posedge clk) disable iff (!rst_n) enq |-> !full);
   a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) deq |-> !empty);

endmodule

// ==== hw/history_table.sv ====
`timescale 1ns/1ps

module history_table #(
   parameter int  NUM_CORE = 4,
   localparam int IDW      = (NUM_CORE > 1) ? $clog2(NUM_CORE) : 1
) (
   input  logic                                   clk,
   input  logic                                   rst_n,
   input  logic [NUM_CORE-1:0]                    hist_req,
   input  logic [NUM_CORE*phold_pkg::LP_ID_WID-1:0] hist_lp,
   output logic [NUM_CORE-1:0]                    hist_gnt
);

   logic [IDW-1:0]       gnt_id;
   logic                 gnt_vld;
   phold_pkg::lp_id_t    wr_lp;
   phold_pkg::hist_cnt_t cnt [phold_pkg::NUM_LP]; // events executed per lp

   rr_arbiter #(
      .N (NUM_CORE)
   ) u_arb (
      .clk     (clk),
      .rst_n   (rst_n),
      .req     (hist_req),
      .advance (gnt_vld),
      .gnt     (hist_gnt),
      .gnt_id  (gnt_id),
      .gnt_vld (gnt_vld)
   );

   assign wr_lp = hist_lp[gnt_id*phold_pkg::LP_ID_WID +: phold_pkg::LP_ID_WID];

   // state save of the granted core
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < phold_pkg::NUM_LP; i++)
            cnt[i] <= '0;
      end else if (gnt_vld) begin
         cnt[wr_lp] <= cnt[wr_lp] + 1'b1;
      end
   end

endmodule

// ==== hw/lfsr.sv ====
`timescale 1ns/1ps

module lfsr (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        next,
   output logic [15:0] rnd
);

   logic [15:0] state;

   // galois form, taps 16 14 13 11
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         state <= phold_pkg::LFSR_SEED;
      else if (next)
         state <= {1'b0, state[15:1]} ^ (state[0] ? 16'hB400 : 16'h0000);
   end

   assign rnd = state;

   // all-zero is a lockup state
   a_state_nonzero: assert property (@(posedge clk) disable iff (!rst_n) state != '0);

endmodule

// ==== hw/phold_core.sv ====
`timescale 1ns/1ps

module phold_core (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 take,
   input  phold_pkg::event_t    in_event,
   input  logic [15:0]          rnd,
   input  logic                 hist_gnt,
   input  logic                 ack,
   output logic                 ready,
   output logic                 busy,
   output phold_pkg::sim_time_t cur_time,
   output logic                 hist_req,
   output phold_pkg::lp_id_t    hist_lp,
   output logic                 out_vld,
   output phold_pkg::event_t    out_event
);

   phold_pkg::core_state_t state;
   phold_pkg::event_t      cur_ev;   // event being executed
   phold_pkg::lp_id_t      dst_lp;   // successor target
   logic [3:0]             delay;
   phold_pkg::sim_time_t   new_time;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= phold_pkg::FREE;
      end else begin
         case (state)
            phold_pkg::FREE:
               if (take)
                  state <= phold_pkg::HIST;
            phold_pkg::HIST:
               if (hist_gnt)
                  state <= phold_pkg::EMIT; // lp counter saved
            phold_pkg::EMIT:
               if (ack)
                  state <= phold_pkg::FREE;
            default:
               state <= phold_pkg::FREE;
         endcase
      end
   end

   // random draw is sampled with the event
   always_ff @(posedge clk) begin
      if (take) begin
         cur_ev <= in_event;
         dst_lp <= rnd[3:0];
         delay  <= rnd[11:8];
      end
   end

   assign cur_time = cur_ev[phold_pkg::TIME_WID-1:0];
   assign hist_lp  = cur_ev[phold_pkg::TIME_WID +: phold_pkg::LP_ID_WID];
   assign new_time = cur_time + phold_pkg::sim_time_t'(delay) + 1'b1; // always in the future

   assign ready     = (state == phold_pkg::FREE);
   assign busy      = (state == phold_pkg::HIST) || (state == phold_pkg::EMIT);
   assign hist_req  = (state == phold_pkg::HIST);
   assign out_vld   = (state == phold_pkg::EMIT);
   assign out_event = {dst_lp, new_time};

   a_take_when_free: assert property (@(posedge clk) disable iff (!rst_n)
      take |-> state == phold_pkg::FREE);

endmodule

// ==== hw/phold_pkg.sv ====
package phold_pkg;

   localparam int TIME_WID  = 16;
   localparam int LP_ID_WID = 4;
   localparam int NUM_LP    = 16;
   localparam int HIST_WID  = 16;

   localparam logic [15:0] LFSR_SEED = 16'hACE1; // any nonzero value

   typedef logic [TIME_WID-1:0]           sim_time_t;
   typedef logic [LP_ID_WID-1:0]          lp_id_t;
   typedef logic [LP_ID_WID+TIME_WID-1:0] event_t;    // {target lp, time}
   typedef logic [HIST_WID-1:0]           hist_cnt_t;

   typedef enum logic [2:0] {
      IDLE,
      INIT,
      READY,
      RUNNING,
      FINISHED
   } ctrl_state_t;

   // per-core event processing
   typedef enum logic [1:0] {
      FREE,
      HIST,
      EMIT
   } core_state_t;

endpackage

// ==== hw/phold_top.sv ====
`timescale 1ns/1ps

module phold_top #(
   parameter int  NUM_CORE    = 4,
   parameter int  QUEUE_DEPTH = 32,
   parameter int  END_TIME    = 200,
   localparam int CIDW        = (NUM_CORE > 1) ? $clog2(NUM_CORE) : 1
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 start,
   output phold_pkg::sim_time_t gvt,
   output logic                 rtn_vld,
   output logic                 exec_vld,
   output phold_pkg::lp_id_t    exec_lp,
   output phold_pkg::sim_time_t exec_time
);

   phold_pkg::ctrl_state_t state;
   phold_pkg::lp_id_t      init_cnt;
   logic                   running;
   logic                   enq, deq, q_empty;
   phold_pkg::event_t      enq_event, q_head;
   logic [15:0]            rnd;
   phold_pkg::sim_time_t   gvt_next;

   logic [NUM_CORE-1:0] core_ready, core_busy, core_take, core_ack;
   logic [NUM_CORE-1:0] core_out_vld, core_hist_req, core_hist_gnt;
   logic [NUM_CORE*phold_pkg::LP_ID_WID-1:0] core_hist_lp;
   phold_pkg::event_t    core_out_event [NUM_CORE];
   phold_pkg::sim_time_t core_time [NUM_CORE];

   logic [NUM_CORE-1:0] disp_gnt, coll_gnt;
   logic                disp_vld, coll_vld;
   logic [CIDW-1:0]     coll_id;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= phold_pkg::IDLE;
         init_cnt <= '0;
         rtn_vld  <= 1'b0;
      end else begin
         rtn_vld <= 1'b0;
         case (state)
            phold_pkg::IDLE:
               if (start)
                  state <= phold_pkg::INIT;
            phold_pkg::INIT:
               if (init_cnt == phold_pkg::NUM_LP - 1)
                  state <= phold_pkg::READY;
            phold_pkg::READY:
               state <= phold_pkg::RUNNING;
            phold_pkg::RUNNING:
               if (gvt > END_TIME) begin
                  state   <= phold_pkg::FINISHED;
                  rtn_vld <= 1'b1;
               end
            phold_pkg::FINISHED:
               state <= phold_pkg::IDLE;
            default:
               state <= phold_pkg::IDLE;
         endcase
         init_cnt <= (state == phold_pkg::INIT) ? init_cnt + 1'b1 : '0; // one lp per cycle
      end
   end

   assign running = (state == phold_pkg::RUNNING);

   // core events first, dispatch only on idle cycles of the queue
   assign enq       = (state == phold_pkg::INIT) || (running && coll_vld);
   assign deq       = running && !coll_vld && !q_empty && disp_vld;
   assign enq_event = (state == phold_pkg::INIT) ? {init_cnt, phold_pkg::TIME_WID'(0)} :
                      core_out_event[coll_id];

   assign core_take = {NUM_CORE{deq}} & disp_gnt;
   assign core_ack  = {NUM_CORE{running}} & coll_gnt;

   assign exec_vld  = deq;
   assign exec_lp   = q_head[phold_pkg::TIME_WID +: phold_pkg::LP_ID_WID];
   assign exec_time = q_head[phold_pkg::TIME_WID-1:0];

   rr_arbiter #(.N(NUM_CORE)) u_disp_arb (
      .clk     (clk),
      .rst_n   (rst_n),
      .req     (core_ready),
      .advance (deq),
      .gnt     (disp_gnt),
      .gnt_id  (),
      .gnt_vld (disp_vld)
   );

   rr_arbiter #(.N(NUM_CORE)) u_coll_arb (
      .clk     (clk),
      .rst_n   (rst_n),
      .req     (core_out_vld),
      .advance (running),
      .gnt     (coll_gnt),
      .gnt_id  (coll_id),
      .gnt_vld (coll_vld)
   );

   event_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
      .clk      (clk),
      .rst_n    (rst_n),
      .enq      (enq),
      .deq      (deq),
      .in_event (enq_event),
      .head     (q_head),
      .empty    (q_empty),
      .full     ()
   );

   lfsr u_lfsr (
      .clk   (clk),
      .rst_n (rst_n),
      .next  (deq),
      .rnd   (rnd)
   );

   history_table #(.NUM_CORE(NUM_CORE)) u_hist (
      .clk      (clk),
      .rst_n    (rst_n),
      .hist_req (core_hist_req),
      .hist_lp  (core_hist_lp),
      .hist_gnt (core_hist_gnt)
   );

   for (genvar g = 0; g < NUM_CORE; g++) begin : g_core
      phold_core u_core (
         .clk       (clk),
         .rst_n     (rst_n),
         .take      (core_take[g]),
         .in_event  (q_head),
         .rnd       (rnd),
         .hist_gnt  (core_hist_gnt[g]),
         .ack       (core_ack[g]),
         .ready     (core_ready[g]),
         .busy      (core_busy[g]),
         .cur_time  (core_time[g]),
         .hist_req  (core_hist_req[g]),
         .hist_lp   (core_hist_lp[g*phold_pkg::LP_ID_WID +: phold_pkg::LP_ID_WID]),
         .out_vld   (core_out_vld[g]),
         .out_event (core_out_event[g])
      );
   end

   // lower bound on any future event time
   always_comb begin
      gvt_next = q_empty ? '1 : q_head[phold_pkg::TIME_WID-1:0];
      for (int i = 0; i < NUM_CORE; i++) begin
         if (core_busy[i] && core_time[i] < gvt_next)
            gvt_next = core_time[i];
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         gvt <= '0;
      else if (state == phold_pkg::IDLE && start)
         gvt <= '0; // new run
      else if (running)
         gvt <= gvt_next;
   end

endmodule

// ==== hw/rr_arbiter.sv ====
`timescale 1ns/1ps

module rr_arbiter #(
   parameter int  N   = 4,
   localparam int IDW = (N > 1) ? $clog2(N) : 1
) (
   input  logic           clk,
   input  logic           rst_n,
   input  logic [N-1:0]   req,
   input  logic           advance,
   output logic [N-1:0]   gnt,
   output logic [IDW-1:0] gnt_id,
   output logic           gnt_vld
);

   logic [IDW-1:0] ptr; // highest priority index

   // first requester at or after ptr, wrapping around
   always_comb begin
      int idx;
      gnt     = '0;
      gnt_id  = '0;
      gnt_vld = 1'b0;
      for (int i = 0; i < N; i++) begin
         idx = (int'(ptr) + i) % N;
         if (!gnt_vld && req[idx]) begin
            gnt[idx] = 1'b1;
            gnt_id   = IDW'(idx);
            gnt_vld  = 1'b1;
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         ptr <= '0;
      else if (advance && gnt_vld)
         ptr <= (int'(gnt_id) == N - 1) ? '0 : gnt_id + 1'b1; // winner goes last
   end

   a_gnt_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(gnt));

endmodule

// ==== tb.f ====
hw/phold_pkg.sv
hw/rr_arbiter.sv
hw/lfsr.sv
hw/event_queue.sv
hw/history_table.sv
hw/phold_core.sv
hw/phold_top.sv
verification/phold_tb.sv

// ==== verification/phold_tb.sv ====
`timescale 1ns/1ps

module phold_tb;

   localparam int NUM_CORE    = 4;
   localparam int QUEUE_DEPTH = 32;
   localparam int END_TIME    = 200;
   localparam int RUN_LIMIT   = 100000; // cycles allowed for one run
   localparam int IDLE_WATCH  = 20;     // quiet cycles checked after a run

   logic                 clk;
   logic                 rst_n;
   logic                 start;
   phold_pkg::sim_time_t gvt;
   logic                 rtn_vld;
   logic                 exec_vld;
   phold_pkg::lp_id_t    exec_lp;
   phold_pkg::sim_time_t exec_time;

   int max_disp_time; // largest dispatched time so far, kept across runs

   phold_top #(
      .NUM_CORE    (NUM_CORE),
      .QUEUE_DEPTH (QUEUE_DEPTH),
      .END_TIME    (END_TIME)
   ) UUT (
      .clk       (clk),
      .rst_n     (rst_n),
      .start     (start),
      .gvt       (gvt),
      .rtn_vld   (rtn_vld),
      .exec_vld  (exec_vld),
      .exec_lp   (exec_lp),
      .exec_time (exec_time)
   );

   initial clk = 1'b0;
   always #4 clk = ~clk; // 8 ns period

   task automatic report_failure(input string reason);
      $display("%s", reason);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check(input string name, input int expected, input int actual);
      if (expected != actual)
         report_failure($sformatf("error: %s expected %0d actual %0d", name, expected, actual));
   endtask

   task automatic apply_reset();
      rst_n = 1'b0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   endtask

   // one-cycle start, gvt must be cleared right after it
   task automatic pulse_start(input string name);
      @(negedge clk);
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
      check({name, " gvt cleared by start"}, 0, gvt);
   endtask

   // follows one run from start to rtn_vld and checks every dispatch
   task automatic watch_run(input string name);
      int        cycles;
      int        n_disp;
      int        prev_gvt;
      bit [15:0] lp_seen;
      bit        done;
      cycles   = 0;
      n_disp   = 0;
      prev_gvt = gvt;
      lp_seen  = '0;
      done     = 1'b0;
      while (!done) begin
         @(negedge clk);
         cycles++;
         if (cycles > RUN_LIMIT)
            report_failure({name, ": rtn_vld did not rise before the run timeout"});
         check({name, " gvt not decreasing"}, 1, int'(gvt) >= prev_gvt);
         prev_gvt = gvt;
         if (exec_vld) begin
            check({name, " exec_time at least gvt"}, 1, exec_time >= gvt);
            if (n_disp < phold_pkg::NUM_LP) begin
               check({name, " initial event time"}, 0, exec_time);
               check({name, " initial lp repeated"}, 0, lp_seen[exec_lp]);
               lp_seen[exec_lp] = 1'b1;
            end else begin
               check({name, " later event time above zero"}, 1, exec_time >= 1);
               check({name, " later event time bound"}, 1,
                     int'(exec_time) <= END_TIME + 16 + max_disp_time);
            end
            if (int'(exec_time) > max_disp_time)
               max_disp_time = exec_time;
            n_disp++;
         end
         if (rtn_vld) begin
            check({name, " gvt past end time"}, 1, int'(gvt) > END_TIME);
            check({name, " initial lps covered"}, 16'hFFFF, lp_seen);
            done = 1'b1;
         end
      end
      // single pulse, then nothing until the next start
      for (int i = 0; i < IDLE_WATCH; i++) begin
         @(negedge clk);
         check({name, " rtn_vld after pulse"}, 0, rtn_vld);
         check({name, " exec_vld after end"}, 0, exec_vld);
      end
   endtask

   task automatic quiet_after_reset();
      for (int i = 0; i < 10; i++) begin
         @(negedge clk);
         check("reset gvt", 0, gvt);
         check("reset rtn_vld", 0, rtn_vld);
         check("reset exec_vld", 0, exec_vld);
      end
   endtask

   task automatic first_run();
      pulse_start("first run");
      watch_run("first run");
   endtask

   // leftover events of the last run stay queued behind the new time-zero ones
   task automatic second_run();
      check("restart gvt held before start", 1, int'(gvt) > END_TIME);
      pulse_start("restart");
      watch_run("restart");
   endtask

   initial begin
      max_disp_time = 0;
      rst_n         = 1'b0;
      start         = 1'b0;
      apply_reset();
      quiet_after_reset();
      first_run();
      second_run();
      $display("TEST PASSED");
      $finish;
   end

endmodule
